//--- common/glb_addr_pkg.sv
/*
 * Address map of the global buffer. Word addressed, no byte lanes.
 * The tile select sits above the bank address, so at most 8 tiles of 64 words.
 */
`default_nettype none

package glb_addr_pkg;

    // tile select field, upper bits of a word address
    localparam int TILE_SEL_ADDR_WIDTH = 3;
    localparam int MAX_NUM_TILES = 2 ** TILE_SEL_ADDR_WIDTH;

    // word address inside one bank
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int BANK_DEPTH = 2 ** BANK_ADDR_WIDTH;

    // full word address: {tile select, bank address}
    localparam int GLB_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH;

    // field positions inside a full address
    localparam int BANK_ADDR_LSB = 0;
    localparam int BANK_ADDR_MSB = BANK_ADDR_LSB + BANK_ADDR_WIDTH - 1;
    localparam int TILE_SEL_ADDR_LSB = BANK_ADDR_MSB + 1;
    localparam int TILE_SEL_ADDR_MSB = GLB_ADDR_WIDTH - 1;

    // one data word
    localparam int GLB_DATA_WIDTH = 32;

endpackage

`default_nettype wire

//--- common/glb_packet_pkg.sv
/*
 * Processor request and response packets carried along the tile chain.
 * A write and a read may share one request. No strobes and no handshake.
 */
`default_nettype none

package glb_packet_pkg;

    // processor request, one per cycle
    typedef struct packed {
        // write half
        logic                                       wr_en;
        logic [glb_addr_pkg::GLB_ADDR_WIDTH-1:0]    wr_addr;
        logic [glb_addr_pkg::GLB_DATA_WIDTH-1:0]    wr_data;
        // read half
        logic                                       rd_en;
        logic [glb_addr_pkg::GLB_ADDR_WIDTH-1:0]    rd_addr;
    } proc_rq_packet_t;

    // read response
    // rd_data only means something while rd_data_valid is set
    typedef struct packed {
        logic                                       rd_data_valid;
        logic [glb_addr_pkg::GLB_DATA_WIDTH-1:0]    rd_data;
    } proc_rs_packet_t;

    // widths of whole packets, handy for checks and dumps
    localparam int PROC_RQ_PACKET_WIDTH = $bits(proc_rq_packet_t);
    localparam int PROC_RS_PACKET_WIDTH = $bits(proc_rs_packet_t);

endpackage

`default_nettype wire

//--- glb_tile/glb_tile_proc_router.sv
/*
 * Even tiles register eastbound traffic and pass westbound traffic, odd tiles the reverse.
 * The core sees the registered request; a core read response replaces the passing one.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_tile_proc_router #(
    parameter int TILE_ID = 0
) (
    input  logic                            clk,
    input  logic                            clk_en,
    input  logic                            reset,

    // request packets
    input  glb_packet_pkg::proc_rq_packet_t proc_rq_packet_wsti,
    input  glb_packet_pkg::proc_rq_packet_t proc_rq_packet_esti,
    output glb_packet_pkg::proc_rq_packet_t proc_rq_packet_wsto,
    output glb_packet_pkg::proc_rq_packet_t proc_rq_packet_esto,
    output glb_packet_pkg::proc_rq_packet_t proc_rq_packet_r2c,

    // response packets
    input  glb_packet_pkg::proc_rs_packet_t proc_rs_packet_wsti,
    input  glb_packet_pkg::proc_rs_packet_t proc_rs_packet_esti,
    input  glb_packet_pkg::proc_rs_packet_t proc_rs_packet_c2r,
    output glb_packet_pkg::proc_rs_packet_t proc_rs_packet_wsto,
    output glb_packet_pkg::proc_rs_packet_t proc_rs_packet_esto
);

    // tile 0 counts as even
    localparam bit IS_EVEN = (TILE_ID % 2) == 0;

    // request side
    glb_packet_pkg::proc_rq_packet_t proc_rq_packet_in;
    glb_packet_pkg::proc_rq_packet_t proc_rq_packet_d1;

    // response side
    glb_packet_pkg::proc_rs_packet_t proc_rs_packet_in;
    glb_packet_pkg::proc_rs_packet_t proc_rs_packet_d1;
    glb_packet_pkg::proc_rs_packet_t proc_rs_packet_c2r_d1;
    glb_packet_pkg::proc_rs_packet_t proc_rs_packet_merged;

    // pick the direction this tile registers
    // even: west in, heading east
    // odd: east in, heading west
    assign proc_rq_packet_in = IS_EVEN ? proc_rq_packet_wsti : proc_rq_packet_esti;
    assign proc_rs_packet_in = IS_EVEN ? proc_rs_packet_wsti : proc_rs_packet_esti;

    // one pipeline stage on the registered direction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_rq_packet_d1 <= '0;
            proc_rs_packet_d1 <= '0;
        end else if (clk_en) begin
            proc_rq_packet_d1 <= proc_rq_packet_in;
            proc_rs_packet_d1 <= proc_rs_packet_in;
        end
    end

    // core response stage
    // lines the core reply up with the passing stream one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_rs_packet_c2r_d1 <= '0;
        end else if (clk_en) begin
            proc_rs_packet_c2r_d1 <= proc_rs_packet_c2r;
        end
    end

    // request outputs
    // registered copy on one side, plain wire-through on the other
    assign proc_rq_packet_esto = IS_EVEN ? proc_rq_packet_d1 : proc_rq_packet_wsti;
    assign proc_rq_packet_wsto = IS_EVEN ? proc_rq_packet_esti : proc_rq_packet_d1;

    // core gets the request as it leaves the register
    assign proc_rq_packet_r2c = proc_rq_packet_d1;

    // core reply wins the slot when valid
    // equal path lengths keep the passing slot empty then
    assign proc_rs_packet_merged = proc_rs_packet_c2r_d1.rd_data_valid
                                 ? proc_rs_packet_c2r_d1 : proc_rs_packet_d1;

    // response outputs
    assign proc_rs_packet_esto = IS_EVEN ? proc_rs_packet_merged : proc_rs_packet_wsti;
    assign proc_rs_packet_wsto = IS_EVEN ? proc_rs_packet_esti : proc_rs_packet_merged;

    // a reply from this core and one from another tile never share a slot
    // holds only while reads enter at tile 0 one per cycle and all loops are equal
    rs_no_collision: assert property (
        @(posedge clk) disable iff (reset)
        proc_rs_packet_c2r_d1.rd_data_valid |-> !proc_rs_packet_d1.rd_data_valid
    ) else $error("tile %0d: core response collides with passing response", TILE_ID);

endmodule

`default_nettype wire

//--- glb_tile/glb_tile_core.sv
/*
 * One 64-word bank per tile. Requests whose tile field differs from TILE_ID are ignored.
 * Reads take one cycle and are read-first against a write to the same word.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_tile_core #(
    parameter int TILE_ID = 0
) (
    input  logic                            clk,
    input  logic                            clk_en,
    input  logic                            reset,

    input  glb_packet_pkg::proc_rq_packet_t proc_rq_packet,
    output glb_packet_pkg::proc_rs_packet_t proc_rs_packet
);

    localparam int TILE_SEL_W = glb_addr_pkg::TILE_SEL_ADDR_WIDTH;
    localparam int BANK_W = glb_addr_pkg::BANK_ADDR_WIDTH;
    localparam int DATA_W = glb_addr_pkg::GLB_DATA_WIDTH;
    localparam int TS_MSB = glb_addr_pkg::TILE_SEL_ADDR_MSB;
    localparam int TS_LSB = glb_addr_pkg::TILE_SEL_ADDR_LSB;
    localparam int BA_MSB = glb_addr_pkg::BANK_ADDR_MSB;
    localparam int BA_LSB = glb_addr_pkg::BANK_ADDR_LSB;

    // this tile's value in the tile field
    localparam logic [TILE_SEL_W-1:0] TILE_SEL = TILE_SEL_W'(TILE_ID);

    // address fields
    logic [TILE_SEL_W-1:0] wr_tile_sel;
    logic [TILE_SEL_W-1:0] rd_tile_sel;
    logic [BANK_W-1:0]     bank_wr_addr;
    logic [BANK_W-1:0]     bank_rd_addr;

    // request targets this bank
    logic wr_hit;
    logic rd_hit;

    // bank storage
    logic [DATA_W-1:0] bank_mem [glb_addr_pkg::BANK_DEPTH];

    // response registers
    logic              rd_data_valid;
    logic [DATA_W-1:0] rd_data;

    assign wr_tile_sel  = proc_rq_packet.wr_addr[TS_MSB:TS_LSB];
    assign rd_tile_sel  = proc_rq_packet.rd_addr[TS_MSB:TS_LSB];
    assign bank_wr_addr = proc_rq_packet.wr_addr[BA_MSB:BA_LSB];
    assign bank_rd_addr = proc_rq_packet.rd_addr[BA_MSB:BA_LSB];

    assign wr_hit = proc_rq_packet.wr_en && (wr_tile_sel == TILE_SEL);
    assign rd_hit = proc_rq_packet.rd_en && (rd_tile_sel == TILE_SEL);

    // write port
    always_ff @(posedge clk) begin
        if (clk_en && wr_hit) begin
            bank_mem[bank_wr_addr] <= proc_rq_packet.wr_data;
        end
    end

    // read port
    // sampling the old word in the same edge gives read-first
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
            rd_data       <= '0;
        end else if (clk_en) begin
            rd_data_valid <= rd_hit;
            if (rd_hit) begin
                rd_data <= bank_mem[bank_rd_addr];
            end
        end
    end

    assign proc_rs_packet.rd_data_valid = rd_data_valid;
    assign proc_rs_packet.rd_data       = rd_data;

    // read and write to one word in the same cycle
    // the reply one cycle later carries the word as it was before the write
    rd_first_same_word: assert property (
        @(posedge clk) disable iff (reset)
        clk_en && rd_hit && wr_hit && (bank_rd_addr == bank_wr_addr)
        |=> proc_rs_packet.rd_data_valid &&
            (proc_rs_packet.rd_data == $past(bank_mem[bank_rd_addr]))
    ) else $error("tile %0d: same-word read did not return the old data", TILE_ID);

endmodule

`default_nettype wire

//--- glb_tile/glb_tile.sv
/*
 * One tile of the chain: request router beside the memory bank.
 * Neighbor ports connect to the adjacent tiles, or loop back at the east end.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic                            clk,
    input  logic                            clk_en,
    input  logic                            reset,

    // request links to neighbors
    input  glb_packet_pkg::proc_rq_packet_t proc_rq_packet_wsti,
    input  glb_packet_pkg::proc_rq_packet_t proc_rq_packet_esti,
    output glb_packet_pkg::proc_rq_packet_t proc_rq_packet_wsto,
    output glb_packet_pkg::proc_rq_packet_t proc_rq_packet_esto,

    // response links to neighbors
    input  glb_packet_pkg::proc_rs_packet_t proc_rs_packet_wsti,
    input  glb_packet_pkg::proc_rs_packet_t proc_rs_packet_esti,
    output glb_packet_pkg::proc_rs_packet_t proc_rs_packet_wsto,
    output glb_packet_pkg::proc_rs_packet_t proc_rs_packet_esto
);

    // router to bank and back
    glb_packet_pkg::proc_rq_packet_t proc_rq_packet_r2c;
    glb_packet_pkg::proc_rs_packet_t proc_rs_packet_c2r;

    glb_tile_proc_router #(
        .TILE_ID (TILE_ID)
    ) i_proc_router (
        .clk                 (clk),
        .clk_en              (clk_en),
        .reset               (reset),
        .proc_rq_packet_wsti (proc_rq_packet_wsti),
        .proc_rq_packet_esti (proc_rq_packet_esti),
        .proc_rq_packet_wsto (proc_rq_packet_wsto),
        .proc_rq_packet_esto (proc_rq_packet_esto),
        .proc_rq_packet_r2c  (proc_rq_packet_r2c),
        .proc_rs_packet_wsti (proc_rs_packet_wsti),
        .proc_rs_packet_esti (proc_rs_packet_esti),
        .proc_rs_packet_c2r  (proc_rs_packet_c2r),
        .proc_rs_packet_wsto (proc_rs_packet_wsto),
        .proc_rs_packet_esto (proc_rs_packet_esto)
    );

    glb_tile_core #(
        .TILE_ID (TILE_ID)
    ) i_core (
        .clk            (clk),
        .clk_en         (clk_en),
        .reset          (reset),
        .proc_rq_packet (proc_rq_packet_r2c),
        .proc_rs_packet (proc_rs_packet_c2r)
    );

endmodule

`default_nettype wire

//--- design/global_buffer.sv
/*
 * Requests enter tile 0 from the west, run east, loop back at the last tile and run west.
 * Read data leaves tile 0 NUM_TILES+2 enabled cycles after the request. No back-pressure.
 */
`timescale 1ns/100ps
`default_nettype none

module global_buffer #(
    parameter int NUM_TILES = 4
) (
    input  logic                                     clk,
    input  logic                                     clk_en,
    input  logic                                     reset,

    // processor write
    input  logic                                     proc_wr_en,
    input  logic [glb_addr_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [glb_addr_pkg::GLB_DATA_WIDTH-1:0]  proc_wr_data,

    // processor read
    input  logic                                     proc_rd_en,
    input  logic [glb_addr_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic [glb_addr_pkg::GLB_DATA_WIDTH-1:0]  proc_rd_data,
    output logic                                     proc_rd_data_valid
);

    // per-tile link arrays, indexed by tile
    glb_packet_pkg::proc_rq_packet_t rq_wsti [NUM_TILES];
    glb_packet_pkg::proc_rq_packet_t rq_esti [NUM_TILES];
    glb_packet_pkg::proc_rq_packet_t rq_wsto [NUM_TILES];
    glb_packet_pkg::proc_rq_packet_t rq_esto [NUM_TILES];
    glb_packet_pkg::proc_rs_packet_t rs_wsti [NUM_TILES];
    glb_packet_pkg::proc_rs_packet_t rs_esti [NUM_TILES];
    glb_packet_pkg::proc_rs_packet_t rs_wsto [NUM_TILES];
    glb_packet_pkg::proc_rs_packet_t rs_esto [NUM_TILES];

    // processor request into tile 0
    glb_packet_pkg::proc_rq_packet_t proc_rq_packet_wsti;

    assign proc_rq_packet_wsti.wr_en   = proc_wr_en;
    assign proc_rq_packet_wsti.wr_addr = proc_wr_addr;
    assign proc_rq_packet_wsti.wr_data = proc_wr_data;
    assign proc_rq_packet_wsti.rd_en   = proc_rd_en;
    assign proc_rq_packet_wsti.rd_addr = proc_rd_addr;

    // read data comes home on tile 0's west side
    // tile 0's westbound request simply dies here
    assign proc_rd_data       = rs_wsto[0].rd_data;
    assign proc_rd_data_valid = rs_wsto[0].rd_data_valid;

    for (genvar k = 0; k < NUM_TILES; k++) begin : gen_tile
        // west side: processor at tile 0, otherwise the western neighbor
        if (k == 0) begin : gen_west_edge
            assign rq_wsti[k] = proc_rq_packet_wsti;
            assign rs_wsti[k] = '0;
        end else begin : gen_west_link
            assign rq_wsti[k] = rq_esto[k-1];
            assign rs_wsti[k] = rs_esto[k-1];
        end

        // east side: loopback at the last tile
        if (k == NUM_TILES - 1) begin : gen_east_loop
            assign rq_esti[k] = rq_esto[k];
            assign rs_esti[k] = rs_esto[k];
        end else begin : gen_east_link
            assign rq_esti[k] = rq_wsto[k+1];
            assign rs_esti[k] = rs_wsto[k+1];
        end

        glb_tile #(
            .TILE_ID (k)
        ) i_tile (
            .clk                 (clk),
            .clk_en              (clk_en),
            .reset               (reset),
            .proc_rq_packet_wsti (rq_wsti[k]),
            .proc_rq_packet_esti (rq_esti[k]),
            .proc_rq_packet_wsto (rq_wsto[k]),
            .proc_rq_packet_esto (rq_esto[k]),
            .proc_rs_packet_wsti (rs_wsti[k]),
            .proc_rs_packet_esti (rs_esti[k]),
            .proc_rs_packet_wsto (rs_wsto[k]),
            .proc_rs_packet_esto (rs_esto[k])
        );
    end

    // equal loop length relies on alternating parity
    // an odd count would leave the last tile without a partner
    num_tiles_legal: assert property (
        @(posedge clk)
        (NUM_TILES % 2 == 0) && (NUM_TILES >= 2) &&
        (NUM_TILES <= glb_addr_pkg::MAX_NUM_TILES)
    ) else $error("NUM_TILES %0d must be even, 2 to %0d",
                  NUM_TILES, glb_addr_pkg::MAX_NUM_TILES);

endmodule

`default_nettype wire

//--- verif/glb_tb_props.sv
/*
 * Monitor for the processor port: reference memory, expected reads, checks.
 * Assumes every read targets an existing tile and every read word was written first.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_tb_props #(
    parameter int NUM_TILES = 4
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    clk_en,
    input  logic                                    proc_wr_en,
    input  logic [glb_addr_pkg::GLB_ADDR_WIDTH-1:0] proc_wr_addr,
    input  logic [glb_addr_pkg::GLB_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                    proc_rd_en,
    input  logic [glb_addr_pkg::GLB_ADDR_WIDTH-1:0] proc_rd_addr,
    input  logic [glb_addr_pkg::GLB_DATA_WIDTH-1:0] proc_rd_data,
    input  logic                                    proc_rd_data_valid,
    output logic                                    check_error,
    output int                                      pending
);

    localparam int DATA_W = glb_addr_pkg::GLB_DATA_WIDTH;
    // register stages on every path: NUM_TILES in the loop, bank read, core response stage
    localparam int LATENCY = NUM_TILES + 2;
    localparam int MEM_DEPTH = 2 ** glb_addr_pkg::GLB_ADDR_WIDTH;

    // set by the testbench for error lines
    string test_name = "none";

    // flat model over all tiles
    logic [DATA_W-1:0] model_mem [MEM_DEPTH];

    // reads in flight, data and due enabled edge
    logic [DATA_W-1:0] exp_data_q [$];
    int                exp_due_q [$];
    int                en_cnt;

    // what the outputs should show after the last edge
    logic              exp_valid;
    logic [DATA_W-1:0] exp_data;

    // outputs and enable seen at the last edge
    logic              prev_clk_en;
    logic              prev_valid;
    logic [DATA_W-1:0] prev_data;

    initial check_error = 1'b0;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            exp_data_q.delete();
            exp_due_q.delete();
            en_cnt      = 0;
            exp_valid   = 1'b0;
            exp_data    = '0;
            pending     = 0;
            prev_clk_en = 1'b1;
            prev_valid  = 1'b0;
            prev_data   = '0;
        end else begin
            prev_clk_en = clk_en;
            prev_valid  = proc_rd_data_valid;
            prev_data   = proc_rd_data;
            if (clk_en) begin
                // head read shows up right after its due edge
                exp_valid = 1'b0;
                if (exp_due_q.size() > 0 && exp_due_q[0] == en_cnt) begin
                    exp_valid = 1'b1;
                    exp_data  = exp_data_q.pop_front();
                    void'(exp_due_q.pop_front());
                end
                // read-first: old word goes into the queue before the write lands
                if (proc_rd_en) begin
                    exp_data_q.push_back(model_mem[proc_rd_addr]);
                    exp_due_q.push_back(en_cnt + LATENCY - 1);
                end
                if (proc_wr_en) begin
                    model_mem[proc_wr_addr] = proc_wr_data;
                end
                en_cnt++;
                pending = exp_due_q.size() + int'(exp_valid);
            end
        end
    end

    // valid exactly when a read is due, so no gaps, no extras
    valid_matches_model: assert property (
        @(posedge clk) disable iff (reset)
        proc_rd_data_valid == exp_valid
    ) else begin
        $display("CHECK FAILED %s rd_data_valid: expected %0b actual %0b",
                 test_name, $sampled(exp_valid), $sampled(proc_rd_data_valid));
        check_error = 1'b1;
    end

    data_matches_model: assert property (
        @(posedge clk) disable iff (reset)
        exp_valid |-> proc_rd_data == exp_data
    ) else begin
        $display("CHECK FAILED %s rd_data: expected %h actual %h",
                 test_name, $sampled(exp_data), $sampled(proc_rd_data));
        check_error = 1'b1;
    end

    // a disabled edge leaves the outputs alone
    outputs_hold_when_disabled: assert property (
        @(posedge clk) disable iff (reset)
        !prev_clk_en |-> (proc_rd_data_valid == prev_valid) && (proc_rd_data == prev_data)
    ) else begin
        $display("CHECK FAILED %s hold: expected %0b/%h actual %0b/%h", test_name,
                 $sampled(prev_valid), $sampled(prev_data),
                 $sampled(proc_rd_data_valid), $sampled(proc_rd_data));
        check_error = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_global_buffer.sv
/*
 * Testbench for the global buffer with 4 tiles. Checking lives in glb_tb_props.
 * Every word is written before random reads start, so no read sees an unwritten bank word.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_global_buffer;

    localparam int NUM_TILES = 4;
    localparam int CLK_PERIOD = 10;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_TIMEOUT = 50;
    localparam int RUN_LIMIT = 20000;
    localparam logic [31:0] RAND_SEED = 32'hf23a_1ee0;
    localparam int ADDR_W = glb_addr_pkg::GLB_ADDR_WIDTH;
    localparam int DATA_W = glb_addr_pkg::GLB_DATA_WIDTH;
    localparam int TS_W = glb_addr_pkg::TILE_SEL_ADDR_WIDTH;
    localparam int BA_W = glb_addr_pkg::BANK_ADDR_WIDTH;
    localparam int BANK_DEPTH = glb_addr_pkg::BANK_DEPTH;

    logic              clk;
    logic              clk_en;
    logic              reset;
    logic              proc_wr_en;
    logic [ADDR_W-1:0] proc_wr_addr;
    logic [DATA_W-1:0] proc_wr_data;
    logic              proc_rd_en;
    logic [ADDR_W-1:0] proc_rd_addr;
    logic [DATA_W-1:0] proc_rd_data;
    logic              proc_rd_data_valid;

    // from the monitor
    logic check_error;
    int   pending_reads;

    global_buffer #(
        .NUM_TILES (NUM_TILES)
    ) i_dut (
        .clk                (clk),
        .clk_en             (clk_en),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid)
    );

    glb_tb_props #(
        .NUM_TILES (NUM_TILES)
    ) i_props (
        .clk                (clk),
        .reset              (reset),
        .clk_en             (clk_en),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .check_error        (check_error),
        .pending            (pending_reads)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // {tile select, bank word}
    function automatic logic [ADDR_W-1:0] make_addr(input int tile, input int word);
        logic [TS_W-1:0] tile_sel;
        logic [BA_W-1:0] bank_addr;
        tile_sel  = TS_W'(tile);
        bank_addr = BA_W'(word);
        return {tile_sel, bank_addr};
    endfunction

    // only tiles that exist
    function automatic logic [ADDR_W-1:0] random_addr();
        return make_addr($urandom_range(NUM_TILES - 1, 0), $urandom_range(BANK_DEPTH - 1, 0));
    endfunction

    // request held through the stall cycles and accepted at the one enabled edge
    task automatic send_request(input logic we, input logic [ADDR_W-1:0] wa,
                                input logic [DATA_W-1:0] wd, input logic re,
                                input logic [ADDR_W-1:0] ra, input int stall);
        proc_wr_en   = we;
        proc_wr_addr = wa;
        proc_wr_data = wd;
        proc_rd_en   = re;
        proc_rd_addr = ra;
        clk_en       = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        clk_en = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // idle until every read in flight has come back and been checked
    task automatic drain_reads();
        int waited;
        send_request(1'b0, '0, '0, 1'b0, '0, 0);
        waited = 0;
        while (pending_reads != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (pending_reads != 0) begin
            $display("%0d reads still outstanding after %0d idle cycles",
                     pending_reads, DRAIN_TIMEOUT);
            $display("Something failed");
            $fatal(1, "simulation stopped");
        end
    endtask

    // global cycle limit and stop at the first failed check
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (check_error !== 1'b1 && cycles < RUN_LIMIT) begin
            @(posedge clk or posedge check_error);
            cycles++;
        end
        if (check_error === 1'b1) begin
            $display("a check on the read port failed");
        end else begin
            $display("no end of run after %0d clock events, timed out", RUN_LIMIT);
        end
        $display("Something failed");
        $fatal(1, "simulation stopped");
    end

    initial begin : stimulus
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        int                stall;
        void'($urandom(RAND_SEED));
        reset        = 1'b1;
        clk_en       = 1'b0;
        proc_wr_en   = 1'b0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset  = 1'b0;
        clk_en = 1'b1;

        // quiet port keeps valid low
        i_props.test_name = "idle after reset";
        repeat (20) send_request(1'b0, '0, '0, 1'b0, '0, 0);

        // fill every bank and read it all back to back
        i_props.test_name = "write and read every word";
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int w = 0; w < BANK_DEPTH; w++) begin
                send_request(1'b1, make_addr(t, w), $urandom, 1'b0, '0, 0);
            end
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int w = 0; w < BANK_DEPTH; w++) begin
                send_request(1'b0, '0, '0, 1'b1, make_addr(t, w), 0);
            end
        end
        drain_reads();

        // one read per cycle over mixed tiles so replies interleave from all tiles
        i_props.test_name = "back to back random reads";
        repeat (200) send_request(1'b0, '0, '0, 1'b1, random_addr(), 0);
        drain_reads();

        // same word read and written in one request returns old data first
        i_props.test_name = "read and write same word";
        for (int i = 0; i < 8; i++) begin
            addr = random_addr();
            data = $urandom;
            send_request(1'b1, addr, data, 1'b1, addr, 0);
            send_request(1'b0, '0, '0, 1'b1, addr, 0);
        end
        drain_reads();

        // mixed traffic with random stalls in front of requests
        i_props.test_name = "stalls during mixed traffic";
        for (int i = 0; i < 300; i++) begin
            stall = ($urandom_range(3, 0) == 0) ? $urandom_range(3, 1) : 0;
            send_request(1'($urandom_range(1, 0)), random_addr(), $urandom,
                         1'($urandom_range(1, 0)), random_addr(), stall);
        end
        drain_reads();

        // a few more edges so the last checks fire
        repeat (3) send_request(1'b0, '0, '0, 1'b0, '0, 0);
        if (check_error === 1'b1) begin
            $display("Something failed");
            $fatal(1, "simulation stopped");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
common/glb_addr_pkg.sv
common/glb_packet_pkg.sv
glb_tile/glb_tile_proc_router.sv
glb_tile/glb_tile_core.sv
glb_tile/glb_tile.sv
design/global_buffer.sv
verif/glb_tb_props.sv
verif/tb_global_buffer.sv
